/* logic/pingpong_defs.svh */
`ifndef PINGPONG_DEFS_SVH
`define PINGPONG_DEFS_SVH

// Packet buffers shared along the path (ping, pang, pong)
`define PP_NUM_BUFFERS 3

// Snooper, CPU and forwarder
`define PP_NUM_AGENTS 3

// Each queue must be able to hold every token at once
`define PP_QUEUE_DEPTH 3

// Token code width, zero is reserved for the empty token
`define PP_TOKEN_W 2

`endif

/* logic/buf_token_pkg.sv */
`include "pingpong_defs.svh"

package buf_token_pkg;

    // A token names one packet buffer
    // The zero code means a queue has nothing to offer
    typedef enum logic [`PP_TOKEN_W-1:0] {
        TOK_NONE = 2'd0,
        TOK_PING = 2'd1,
        TOK_PANG = 2'd2,
        TOK_PONG = 2'd3
    } buf_token_e;

    // Select code for a buffer data multiplexer
    // Codes line up with the agent order plus one
    typedef enum logic [1:0] {
        OWN_NONE  = 2'd0,
        OWN_SNOOP = 2'd1,
        OWN_CPU   = 2'd2,
        OWN_FWD   = 2'd3
    } owner_sel_e;

    // Buffer side view of ownership, one select per buffer
    // Ping sits in the top bits
    typedef struct packed {
        owner_sel_e ping;
        owner_sel_e pang;
        owner_sel_e pong;
    } buf_route_t;

endpackage

/* logic/agent_pkg.sv */
package agent_pkg;

    // Agent order, also the index into every per agent array
    typedef enum logic [1:0] {
        AGENT_SNOOP = 2'd0,
        AGENT_CPU   = 2'd1,
        AGENT_FWD   = 2'd2
    } agent_e;

    // Handshake unit state
    // Idle waits for a start, started waits for a finish
    typedef enum logic {
        HS_IDLE    = 1'b0,
        HS_STARTED = 1'b1
    } hs_state_e;

    // Levels driven by an agent
    // The reject bit only has meaning on the CPU
    typedef struct packed {
        logic done;
        logic reject;
        logic rdy_ack;
    } agent_req_t;

    // Levels driven back to an agent by the controller
    typedef struct packed {
        logic rdy;
        logic done_ack;
    } agent_ctl_t;

    // Completed handshake events, each high for one cycle
    typedef struct packed {
        logic fin;
        logic rej;
    } agent_evt_t;

    // What the router does with a finishing agent's token
    typedef enum logic [1:0] {
        OP_NONE   = 2'd0,
        OP_PASS   = 2'd1,
        OP_RETURN = 2'd2
    } queue_op_e;

endpackage

/* logic/agent_handshake.sv */
`timescale 1ns/100ps

module agent_handshake (
    input  logic                      clk,
    input  logic                      rst,
    input  buf_token_pkg::buf_token_e head_i,
    input  agent_pkg::agent_req_t     req_i,
    output agent_pkg::agent_ctl_t     ctl_o,
    output agent_pkg::agent_evt_t     evt_o
);

    import buf_token_pkg::*;
    import agent_pkg::*;

    hs_state_e state_q;
    hs_state_e state_d;

    // Local copies of the outgoing levels so the events can use them
    logic rdy;
    logic done_ack;

    // Both sides agree in the same cycle
    logic start;
    logic finish;

    // Ready is only offered while the agent's queue head names a buffer
    assign rdy      = (state_q == HS_IDLE) && (head_i != TOK_NONE);
    // Done is acknowledged for as long as the agent works on its buffer
    assign done_ack = (state_q == HS_STARTED);

    assign start  = rdy && req_i.rdy_ack;
    assign finish = req_i.done && done_ack;

    // Move to started after a start, back to idle after a finish
    always_comb begin
        state_d = state_q;
        case (state_q)
            HS_IDLE: begin
                if (start) begin
                    state_d = HS_STARTED;
                end
            end
            HS_STARTED: begin
                if (finish) begin
                    state_d = HS_IDLE;
                end
            end
            default: state_d = HS_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= HS_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign ctl_o.rdy      = rdy;
    assign ctl_o.done_ack = done_ack;

    // The router decides whether a reject matters for this agent
    assign evt_o.fin = finish;
    assign evt_o.rej = finish && req_i.reject;

endmodule

/* logic/token_queue.sv */
`timescale 1ns/100ps
`include "pingpong_defs.svh"

module token_queue #(
    parameter int PUSH_SLOTS = 1,
    parameter int PRELOAD    = 0
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      pop_i,
    input  logic [PUSH_SLOTS-1:0]     push_valid_i,
    input  buf_token_pkg::buf_token_e push_tok_i [PUSH_SLOTS],
    output buf_token_pkg::buf_token_e head_o
);

    import buf_token_pkg::*;

    localparam int DEPTH       = `PP_QUEUE_DEPTH;
    localparam int PTR_W       = $clog2(DEPTH);
    localparam int CNT_W       = $clog2(DEPTH + 1);
    // A preloaded queue starts full of ping, pang, pong
    localparam int PRELOAD_CNT = `PP_NUM_BUFFERS;
    localparam int PRELOAD_WR  = `PP_NUM_BUFFERS % DEPTH;
    localparam bit DO_PRELOAD  = (PRELOAD != 0);

    buf_token_e       mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;

    // Write slot for each push lane and where the write pointer ends up
    logic [PTR_W-1:0] slot_ptr [PUSH_SLOTS];
    logic [PTR_W-1:0] wr_ptr_next;
    logic [CNT_W-1:0] push_cnt;

    // Circular increment, the depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        if (ptr == PTR_W'(DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    // Lanes are taken in index order, a lane that is idle takes no slot
    always_comb begin
        wr_ptr_next = wr_ptr;
        push_cnt    = '0;
        for (int k = 0; k < PUSH_SLOTS; k++) begin
            slot_ptr[k] = wr_ptr_next;
            if (push_valid_i[k]) begin
                wr_ptr_next = ptr_inc(wr_ptr_next);
                push_cnt    = push_cnt + 1'b1;
            end
        end
    end

    // Pointers and count
    // Only three tokens exist, so the count can never pass the depth
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= DO_PRELOAD ? PTR_W'(PRELOAD_WR) : '0;
            count  <= DO_PRELOAD ? CNT_W'(PRELOAD_CNT) : '0;
        end else begin
            if (pop_i) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            wr_ptr <= wr_ptr_next;
            count  <= count + push_cnt - CNT_W'(pop_i);
        end
    end

    // Token storage, only written at reset when preloading
    always_ff @(posedge clk) begin
        if (rst) begin
            if (DO_PRELOAD) begin
                for (int b = 0; b < `PP_NUM_BUFFERS; b++) begin
                    mem[b] <= buf_token_e'(b + 1);
                end
            end
        end else begin
            for (int k = 0; k < PUSH_SLOTS; k++) begin
                if (push_valid_i[k]) begin
                    mem[slot_ptr[k]] <= push_tok_i[k];
                end
            end
        end
    end

    // An empty queue offers nothing
    assign head_o = (count == '0) ? TOK_NONE : mem[rd_ptr];

endmodule

/* logic/queue_router.sv */
`timescale 1ns/100ps
`include "pingpong_defs.svh"

module queue_router (
    input  logic                      clk,
    input  logic                      rst,
    input  agent_pkg::agent_evt_t     evt_i  [`PP_NUM_AGENTS],
    output buf_token_pkg::buf_token_e head_o [`PP_NUM_AGENTS]
);

    import buf_token_pkg::*;
    import agent_pkg::*;

    // One opcode per agent, indexed by agent_e
    queue_op_e op [`PP_NUM_AGENTS];
    logic [`PP_NUM_AGENTS-1:0] pop;

    // Snooper queue takes two returns, CPU reject on lane 0 so it lands first
    logic [1:0] snp_push_valid;
    buf_token_e snp_push_tok [2];
    logic [0:0] cpu_push_valid;
    buf_token_e cpu_push_tok [1];
    logic [0:0] fwd_push_valid;
    buf_token_e fwd_push_tok [1];

    // Event decode
    // The reject flag only counts for the CPU
    always_comb begin
        op[AGENT_SNOOP] = evt_i[AGENT_SNOOP].fin ? OP_PASS : OP_NONE;

        if (!evt_i[AGENT_CPU].fin) begin
            op[AGENT_CPU] = OP_NONE;
        end else if (evt_i[AGENT_CPU].rej) begin
            op[AGENT_CPU] = OP_RETURN;
        end else begin
            op[AGENT_CPU] = OP_PASS;
        end

        // The forwarder always sends its buffer home
        op[AGENT_FWD] = evt_i[AGENT_FWD].fin ? OP_RETURN : OP_NONE;
    end

    // A finishing agent gives up its head token at the closing edge
    always_comb begin
        for (int a = 0; a < `PP_NUM_AGENTS; a++) begin
            pop[a] = (op[a] != OP_NONE);
        end
    end

    // Returns go back to the snooper
    assign snp_push_valid[0] = (op[AGENT_CPU] == OP_RETURN);
    assign snp_push_tok[0]   = head_o[AGENT_CPU];
    assign snp_push_valid[1] = (op[AGENT_FWD] == OP_RETURN);
    assign snp_push_tok[1]   = head_o[AGENT_FWD];

    // A filled buffer goes on to the CPU
    assign cpu_push_valid[0] = (op[AGENT_SNOOP] == OP_PASS);
    assign cpu_push_tok[0]   = head_o[AGENT_SNOOP];

    // An accepted buffer goes on to the forwarder
    assign fwd_push_valid[0] = (op[AGENT_CPU] == OP_PASS);
    assign fwd_push_tok[0]   = head_o[AGENT_CPU];

    // The snooper starts out owning every buffer
    token_queue #(
        .PUSH_SLOTS (2),
        .PRELOAD    (1)
    ) u_snp_queue (
        .clk          (clk),
        .rst          (rst),
        .pop_i        (pop[AGENT_SNOOP]),
        .push_valid_i (snp_push_valid),
        .push_tok_i   (snp_push_tok),
        .head_o       (head_o[AGENT_SNOOP])
    );

    token_queue #(
        .PUSH_SLOTS (1),
        .PRELOAD    (0)
    ) u_cpu_queue (
        .clk          (clk),
        .rst          (rst),
        .pop_i        (pop[AGENT_CPU]),
        .push_valid_i (cpu_push_valid),
        .push_tok_i   (cpu_push_tok),
        .head_o       (head_o[AGENT_CPU])
    );

    token_queue #(
        .PUSH_SLOTS (1),
        .PRELOAD    (0)
    ) u_fwd_queue (
        .clk          (clk),
        .rst          (rst),
        .pop_i        (pop[AGENT_FWD]),
        .push_valid_i (fwd_push_valid),
        .push_tok_i   (fwd_push_tok),
        .head_o       (head_o[AGENT_FWD])
    );

endmodule

/* logic/buffer_route.sv */
`timescale 1ns/100ps
`include "pingpong_defs.svh"

module buffer_route (
    input  buf_token_pkg::buf_token_e head_i [`PP_NUM_AGENTS],
    output buf_token_pkg::buf_route_t route_o
);

    import buf_token_pkg::*;
    import agent_pkg::*;

    // Owner per buffer, index 0 is ping
    owner_sel_e owner [`PP_NUM_BUFFERS];

    // Map an agent onto its multiplexer select code
    function automatic owner_sel_e agent_sel(input agent_e agent);
        owner_sel_e sel;
        case (agent)
            AGENT_SNOOP: sel = OWN_SNOOP;
            AGENT_CPU:   sel = OWN_CPU;
            AGENT_FWD:   sel = OWN_FWD;
            default:     sel = OWN_NONE;
        endcase
        return sel;
    endfunction

    // Only queue heads count as owned
    // A token waiting further back belongs to nobody yet
    always_comb begin
        for (int b = 0; b < `PP_NUM_BUFFERS; b++) begin
            owner[b] = OWN_NONE;
            for (int a = 0; a < `PP_NUM_AGENTS; a++) begin
                if (head_i[a] == buf_token_e'(b + 1)) begin
                    owner[b] = agent_sel(agent_e'(a));
                end
            end
        end
    end

    assign route_o.ping = owner[0];
    assign route_o.pang = owner[1];
    assign route_o.pong = owner[2];

endmodule

/* logic/pingpong_ctrl.sv */
`timescale 1ns/100ps
`include "pingpong_defs.svh"

module pingpong_ctrl (
    input  logic                      clk,
    input  logic                      rst,
    input  agent_pkg::agent_req_t     agent_req_i [`PP_NUM_AGENTS],
    output agent_pkg::agent_ctl_t     agent_ctl_o [`PP_NUM_AGENTS],
    output buf_token_pkg::buf_token_e agent_buf_o [`PP_NUM_AGENTS],
    output buf_token_pkg::buf_route_t route_o
);

    import buf_token_pkg::*;
    import agent_pkg::*;

    // Current head of each agent's token queue
    buf_token_e head [`PP_NUM_AGENTS];

    // Finished and rejected events fed back to the router
    agent_evt_t evt [`PP_NUM_AGENTS];

    // Token queues and the routing of finished tokens
    queue_router u_router (
        .clk    (clk),
        .rst    (rst),
        .evt_i  (evt),
        .head_o (head)
    );

    // One handshake unit per agent
    // Each one only sees its own queue head and its own agent
    for (genvar k = 0; k < `PP_NUM_AGENTS; k++) begin : g_agent
        localparam agent_e AGENT = agent_e'(k);

        agent_handshake u_hs (
            .clk    (clk),
            .rst    (rst),
            .head_i (head[AGENT]),
            .req_i  (agent_req_i[AGENT]),
            .ctl_o  (agent_ctl_o[AGENT]),
            .evt_o  (evt[AGENT])
        );
    end

    // Buffer side view for the data multiplexers
    buffer_route u_route (
        .head_i  (head),
        .route_o (route_o)
    );

    // Agent side view is the queue heads themselves
    assign agent_buf_o = head;

endmodule

/* bench/pingpong_ctrl_tb.sv */
`timescale 1ns/100ps
`include "pingpong_defs.svh"

module pingpong_ctrl_tb;

    import buf_token_pkg::*;
    import agent_pkg::*;

    localparam int WAIT_LIMIT = 50;

    logic       clk;
    logic       rst;
    agent_req_t req     [`PP_NUM_AGENTS];
    agent_ctl_t ctl     [`PP_NUM_AGENTS];
    buf_token_e buf_tok [`PP_NUM_AGENTS];
    buf_route_t route;

    // Reference queues and handshake states, one per agent
    buf_token_e snp_q [$];
    buf_token_e cpu_q [$];
    buf_token_e fwd_q [$];
    logic [`PP_NUM_AGENTS-1:0] started;
    string agent_names [`PP_NUM_AGENTS] = '{"snoop", "cpu", "fwd"};

    pingpong_ctrl uut (
        .clk         (clk),
        .rst         (rst),
        .agent_req_i (req),
        .agent_ctl_o (ctl),
        .agent_buf_o (buf_tok),
        .route_o     (route)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic fail_run();
        $display("Verification failed");
        $fatal(1);
    endtask

    // The head of an empty queue reads as the empty token
    function automatic buf_token_e model_head(input int a);
        buf_token_e t;
        t = TOK_NONE;
        case (a)
            0: if (snp_q.size() > 0) t = snp_q[0];
            1: if (cpu_q.size() > 0) t = cpu_q[0];
            2: if (fwd_q.size() > 0) t = fwd_q[0];
            default: t = TOK_NONE;
        endcase
        return t;
    endfunction

    // Each buffer is owned by whichever agent has it at the queue head
    function automatic buf_route_t model_route();
        buf_route_t r;
        owner_sel_e sel;
        r = '0;
        for (int a = 0; a < `PP_NUM_AGENTS; a++) begin
            case (a)
                0: sel = OWN_SNOOP;
                1: sel = OWN_CPU;
                default: sel = OWN_FWD;
            endcase
            case (model_head(a))
                TOK_PING: r.ping = sel;
                TOK_PANG: r.pang = sel;
                TOK_PONG: r.pong = sel;
                default: ;
            endcase
        end
        return r;
    endfunction

    // Snooper passes to CPU, CPU passes or returns, forwarder always returns
    task automatic model_finish(input int a, input bit rej);
        buf_token_e t;
        case (a)
            0: begin
                t = snp_q.pop_front();
                cpu_q.push_back(t);
            end
            1: begin
                t = cpu_q.pop_front();
                if (rej) snp_q.push_back(t);
                else fwd_q.push_back(t);
            end
            default: begin
                t = fwd_q.pop_front();
                snp_q.push_back(t);
            end
        endcase
        started[a] = 1'b0;
    endtask

    task automatic check_token(input string tname, input string what,
                               input buf_token_e exp, input buf_token_e act);
        if (exp !== act) begin
            $display("mismatch %s %s: expected %s actual %s",
                     tname, what, exp.name(), act.name());
            fail_run();
        end
    endtask

    task automatic check_route(input string tname, input buf_route_t exp,
                               input buf_route_t act);
        if (exp !== act) begin
            $display("mismatch %s route: expected %b actual %b", tname, exp, act);
            fail_run();
        end
    endtask

    task automatic check_ctl(input string tname, input string what,
                             input agent_ctl_t exp, input agent_ctl_t act);
        if (exp !== act) begin
            $display("mismatch %s %s: expected %b actual %b", tname, what, exp, act);
            fail_run();
        end
    endtask

    // Compare every agent view and the buffer view against the model
    task automatic check_all(input string tname);
        agent_ctl_t exp_ctl;
        for (int a = 0; a < `PP_NUM_AGENTS; a++) begin
            exp_ctl.rdy      = !started[a] && (model_head(a) != TOK_NONE);
            exp_ctl.done_ack = started[a];
            check_token(tname, {"buf_", agent_names[a]}, model_head(a), buf_tok[a]);
            check_ctl(tname, {"ctl_", agent_names[a]}, exp_ctl, ctl[a]);
        end
        check_route(tname, model_route(), route);
    endtask

    // Poll one control level at each falling edge until it rises
    task automatic wait_level(input string tname, input int a, input bit want_rdy);
        int cycles;
        cycles = 0;
        while (want_rdy ? !ctl[a].rdy : !ctl[a].done_ack) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                $display("%s: %s never raised %s", tname, agent_names[a],
                         want_rdy ? "ready" : "done acknowledge");
                fail_run();
            end
        end
    endtask

    // The agent idles a random 0 to 3 cycles, then acknowledges ready for one cycle
    task automatic do_start(input string tname, input int a);
        int gap;
        wait_level(tname, a, 1'b1);
        gap = $urandom_range(3, 0);
        repeat (gap) begin
            @(negedge clk);
            check_all(tname);
        end
        req[a].rdy_ack = 1'b1;
        @(negedge clk);
        req[a].rdy_ack = 1'b0;
        started[a] = 1'b1;
        check_all(tname);
    endtask

    // Done is raised for one cycle, new heads show one cycle after the finish
    task automatic do_finish(input string tname, input int a, input bit rej);
        wait_level(tname, a, 1'b0);
        req[a].done   = 1'b1;
        req[a].reject = rej;
        @(negedge clk);
        req[a] = '0;
        model_finish(a, rej);
        check_all(tname);
    endtask

    // CPU reject and forwarder done close in the same cycle
    task automatic do_pair(input string tname);
        wait_level(tname, 1, 1'b0);
        wait_level(tname, 2, 1'b0);
        req[1].done   = 1'b1;
        req[1].reject = 1'b1;
        req[2].done   = 1'b1;
        @(negedge clk);
        req[1] = '0;
        req[2] = '0;
        // The CPU token must land in the snooper queue ahead of the forwarder's
        model_finish(1, 1'b1);
        model_finish(2, 1'b0);
        check_all(tname);
    endtask

    function automatic int agent_index(input string s);
        if (s == "snoop") return 0;
        if (s == "cpu") return 1;
        if (s == "fwd") return 2;
        if (s == "cpu_fwd") return 3;
        return -1;
    endfunction

    initial begin
        int    seed_ret;
        int    fd;
        int    rc;
        int    a;
        int    count;
        string line;
        string tname;
        string agent_str;
        string action;

        seed_ret = $urandom(32'hf74591ec);
        rst = 1'b1;
        started = '0;
        for (int k = 0; k < `PP_NUM_AGENTS; k++) begin
            req[k] = '0;
        end
        snp_q = '{TOK_PING, TOK_PANG, TOK_PONG};
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_all("reset_state");

        fd = $fopen("bench/pingpong_ctrl_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file");
            fail_run();
        end
        while (!$feof(fd)) begin
            if ($fgets(line, fd) == 0) break;
            if (line.len() < 2 || line.substr(0, 0) == "#") continue;
            rc = $sscanf(line, "%s %s %s %d", tname, agent_str, action, count);
            a = agent_index(agent_str);
            if (rc != 4 || a < 0) begin
                $display("Malformed stimulus line: %s", line);
                fail_run();
            end
            if (action == "start") do_start(tname, a);
            else if (action == "done") do_finish(tname, a, 1'b0);
            else if (action == "accept") do_finish(tname, a, 1'b0);
            else if (action == "reject" && a == 3) do_pair(tname);
            else if (action == "reject") do_finish(tname, a, 1'b1);
            else if (action == "hold") begin
                // Acknowledge stays low, so nothing may move
                repeat (count) begin
                    @(negedge clk);
                    check_all(tname);
                end
            end else begin
                $display("Unknown action %s in test %s", action, tname);
                fail_run();
            end
        end
        $fclose(fd);
        $display("Verification passed");
        $finish;
    end

endmodule

/* pingpong_ctrl.f */
+incdir+logic
logic/buf_token_pkg.sv
logic/agent_pkg.sv
logic/agent_handshake.sv
logic/token_queue.sv
logic/queue_router.sv
logic/buffer_route.sv
logic/pingpong_ctrl.sv
bench/pingpong_ctrl_tb.sv

/* bench/pingpong_ctrl_stimulus.txt */
# Columns: test name, agent (snoop cpu fwd cpu_fwd), action, cycle count for hold
# Actions: start done accept reject hold
reset_state  snoop    hold    2
full_pass    snoop    start   0
full_pass    snoop    done    0
full_pass    cpu      start   0
full_pass    cpu      accept  0
full_pass    fwd      start   0
full_pass    fwd      done    0
reject       snoop    start   0
reject       snoop    done    0
reject       cpu      start   0
reject       cpu      reject  0
reject       fwd      hold    3
in_flight    snoop    start   0
in_flight    snoop    done    0
in_flight    cpu      start   0
in_flight    cpu      accept  0
in_flight    fwd      start   0
in_flight    snoop    start   0
in_flight    snoop    done    0
in_flight    cpu      start   0
in_flight    snoop    start   0
in_flight    snoop    hold    2
in_flight    snoop    done    0
same_cycle   cpu_fwd  reject  0
stalls       snoop    hold    4
stalls       snoop    start   0
stalls       snoop    done    0
stalls       cpu      hold    3
stalls       cpu      start   0
stalls       cpu      accept  0
stalls       fwd      hold    2
stalls       fwd      start   0
stalls       fwd      done    0
